//--- Makefile
VERILATOR ?= verilator
TOP       ?= fe_tb
RTL_TOP   ?= fe_top
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q '^\*\* PASS \*\*$$' $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- design/fe_cmd_decode.sv
// Command decoder that turns back end strobes into controller requests
`timescale 1ns/1ps

module fe_cmd_decode (
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  logic                           fe_cmd_v_i,
  input  fe_pkg::fe_opcode_e             fe_cmd_opcode_i,
  input  logic [fe_pkg::VADDR_WIDTH-1:0] fe_cmd_vaddr_i,
  fe_cmd_if.source                       cmd
);
  import fe_pkg::*;

  assign cmd.reset_v    = fe_cmd_v_i & (fe_cmd_opcode_i == e_op_state_reset);
  assign cmd.redirect_v = fe_cmd_v_i & (fe_cmd_opcode_i == e_op_pc_redirect);
  assign cmd.wait_v     = fe_cmd_v_i & (fe_cmd_opcode_i == e_op_wait);

  // Unknown opcodes are ignored rather than flushing with no follow-up
  assign cmd.cmd_flush = cmd.reset_v | cmd.redirect_v | cmd.wait_v;

  assign cmd.cmd_pc = fe_cmd_vaddr_i;

  a_one_request: assert property (
    @(posedge clk_i) disable iff (reset_i)
    $onehot0({cmd.reset_v, cmd.redirect_v, cmd.wait_v})
  ) else $error("more than one command request in a cycle");

  a_request_flushes: assert property (
    @(posedge clk_i) disable iff (reset_i)
    fe_cmd_v_i |-> cmd.cmd_flush
  ) else $error("command strobe with unknown opcode");

endmodule

//--- design/fe_fetch_stage.sv
// IF1 stage that issues instruction reads, checks fetch faults and feeds IF2
`timescale 1ns/1ps

module fe_fetch_stage (
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  logic                           next_v_i,
  input  logic [fe_pkg::VADDR_WIDTH-1:0] next_pc_i,
  output logic                           imem_v_o,
  output logic [fe_pkg::VADDR_WIDTH-1:0] imem_addr_o,
  input  logic                           fetch_fail_i,
  input  logic                           exc_v_i,
  fe_cmd_if.monitor                      cmd,
  fe_stage_if.source                     stage
);
  import fe_pkg::*;

  logic                   v_if1_r;
  logic [VADDR_WIDTH-1:0] pc_if1_r;
  logic                   misaligned;
  logic                   access_fault;
  logic                   kill_if1;
  logic                   v_if2_r;
  logic [VADDR_WIDTH-1:0] pc_if2_r;
  logic                   misaligned_r;
  logic                   access_fault_r;

  assign misaligned   = |pc_if1_r[1:0];
  assign access_fault = (pc_if1_r >= IMEM_LIMIT);

  // Any redirect of the stream poisons the item sitting in IF1
  assign kill_if1 = cmd.cmd_flush | fetch_fail_i | exc_v_i;

  // Faulting PCs go down the pipe without touching memory
  assign imem_v_o    = v_if1_r & ~misaligned & ~access_fault & ~kill_if1;
  assign imem_addr_o = pc_if1_r;

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      v_if1_r <= 1'b0;
      v_if2_r <= 1'b0;
    end
    else
    begin
      v_if1_r <= next_v_i;
      v_if2_r <= v_if1_r & ~kill_if1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    pc_if1_r       <= next_pc_i;
    pc_if2_r       <= pc_if1_r;
    misaligned_r   <= misaligned;
    access_fault_r <= access_fault;
  end

  assign stage.if2_v            = v_if2_r;
  assign stage.if2_pc           = pc_if2_r;
  assign stage.if2_misaligned   = misaligned_r;
  assign stage.if2_access_fault = access_fault_r;

endmodule

//--- design/fe_if.sv
// Internal front end interfaces for decoded commands and the IF1 to IF2 handoff
`timescale 1ns/1ps

interface fe_cmd_if;
  import fe_pkg::*;

  logic                   reset_v;
  logic                   redirect_v;
  logic                   wait_v;
  logic                   cmd_flush;
  logic [VADDR_WIDTH-1:0] cmd_pc;

  modport source (output reset_v, redirect_v, wait_v, cmd_flush, cmd_pc);
  modport sink (input reset_v, redirect_v, wait_v, cmd_flush, cmd_pc);

  // Pipeline stages only need to know that a command killed them
  modport monitor (input cmd_flush);
endinterface

interface fe_stage_if (input logic clk_i, input logic reset_i);
  import fe_pkg::*;

  logic                   if2_v;
  logic [VADDR_WIDTH-1:0] if2_pc;
  logic                   if2_misaligned;
  logic                   if2_access_fault;

  modport source (output if2_v, if2_pc, if2_misaligned, if2_access_fault);
  modport sink (
    input clk_i,
    input reset_i,
    input if2_v,
    input if2_pc,
    input if2_misaligned,
    input if2_access_fault
  );
endinterface

//--- design/fe_pc_gen.sv
// Fetch controller with wait/run/stall FSM, resume PC and next fetch address
`timescale 1ns/1ps

module fe_pc_gen (
  input  logic                           clk_i,
  input  logic                           reset_i,
  fe_cmd_if.sink                         cmd,
  input  logic [fe_pkg::VADDR_WIDTH-1:0] if2_pc_i,
  input  logic                           fetch_fail_i,
  input  logic                           exc_v_i,
  input  logic                           imem_ready_i,
  output logic                           next_v_o,
  output logic [fe_pkg::VADDR_WIDTH-1:0] next_pc_o
);
  import fe_pkg::*;

  fe_state_e              state_r;
  fe_state_e              state_n;
  logic [VADDR_WIDTH-1:0] pc_r;
  logic [VADDR_WIDTH-1:0] pc_n;

  always_comb
  begin
    state_n = state_r;
    if (cmd.redirect_v)
      state_n = e_run;
    else if (cmd.reset_v)
      state_n = e_stall;
    else if (cmd.wait_v)
      state_n = e_wait;
    else
    begin
      case (state_r)
        e_wait:  state_n = e_wait;
        // Restart only once the queue can take what we fetch
        e_stall: state_n = imem_ready_i ? e_run : e_stall;
        e_run:
        begin
          if (fetch_fail_i)
            state_n = e_stall;
          else if (exc_v_i)
            state_n = e_wait;
        end
        default: state_n = e_wait;
      endcase
    end
  end

  // Redirect target goes out in the same cycle
  assign next_pc_o = cmd.redirect_v ? cmd.cmd_pc : pc_r;
  assign next_v_o  = (state_n == e_run);

  always_comb
  begin
    if (fetch_fail_i && !cmd.cmd_flush)
      pc_n = if2_pc_i;
    else if (next_v_o)
      pc_n = next_pc_o + FETCH_STRIDE;
    else if (cmd.cmd_flush)
      pc_n = cmd.cmd_pc;
    else
      pc_n = pc_r;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      state_r <= e_wait;
    else
      state_r <= state_n;
  end

  always_ff @(posedge clk_i)
  begin
    pc_r <= pc_n;
  end

  a_no_fetch_in_wait: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (state_r == e_wait) && !cmd.redirect_v |-> !next_v_o
  ) else $error("fetch issued while waiting for a command");

  // A failed item must be the next address fetched
  a_fail_resumes: assert property (
    @(posedge clk_i) disable iff (reset_i)
    fetch_fail_i && !cmd.cmd_flush |=> (state_r == e_stall) && (pc_r == $past(if2_pc_i))
  ) else $error("fetch failure did not rewind the resume PC");

endmodule

//--- design/fe_pkg.sv
// Fetch front end package with widths, command and message encodings
package fe_pkg;

  localparam int VADDR_WIDTH = 32;
  localparam int INSTR_WIDTH = 32;

  // First byte address past the instruction memory
  localparam logic [VADDR_WIDTH-1:0] IMEM_LIMIT = 32'h0000_1000;

  localparam logic [VADDR_WIDTH-1:0] FETCH_STRIDE = 32'd4;

  // Back end command opcodes
  typedef enum logic [1:0]
  {
    e_op_state_reset = 2'd0,
    e_op_pc_redirect = 2'd1,
    e_op_wait        = 2'd2
  } fe_opcode_e;

  // Fetch controller states
  typedef enum logic [1:0]
  {
    e_wait  = 2'd0,
    e_run   = 2'd1,
    e_stall = 2'd2
  } fe_state_e;

  typedef enum logic
  {
    e_fe_fetch     = 1'b0,
    e_fe_exception = 1'b1
  } fe_msg_type_e;

  typedef enum logic [1:0]
  {
    e_instr_misaligned   = 2'd0,
    e_instr_access_fault = 2'd1
  } fe_exc_code_e;

  // Queue payload read as an instruction or as an exception record
  typedef union packed
  {
    logic [INSTR_WIDTH-1:0] instr;
    struct packed
    {
      logic [INSTR_WIDTH-3:0] zero;
      fe_exc_code_e           code;
    } exc;
  } fe_msg_u;

endpackage

//--- design/fe_queue_stage.sv
// IF2 stage that builds fetch queue messages and reports progress or failure
`timescale 1ns/1ps

module fe_queue_stage (
  fe_stage_if.sink                       stage,
  fe_cmd_if.monitor                      cmd,
  input  logic [fe_pkg::INSTR_WIDTH-1:0] imem_data_i,
  input  logic                           fe_queue_ready_i,
  output logic                           fe_queue_v_o,
  output fe_pkg::fe_msg_type_e           fe_queue_type_o,
  output logic [fe_pkg::VADDR_WIDTH-1:0] fe_queue_pc_o,
  output fe_pkg::fe_msg_u                fe_queue_payload_o,
  output logic                           fetch_fail_o,
  output logic                           exc_v_o
);
  import fe_pkg::*;

  logic    exc_item;
  fe_msg_u msg;

  assign exc_item = stage.if2_misaligned | stage.if2_access_fault;

  // Only offer a message the queue will take this cycle
  assign fe_queue_v_o = stage.if2_v & fe_queue_ready_i & ~cmd.cmd_flush;
  assign fetch_fail_o = stage.if2_v & ~fe_queue_v_o;
  assign exc_v_o      = fe_queue_v_o & exc_item;

  always_comb
  begin
    msg = '0;
    if (exc_item)
      // Misaligned wins when both faults apply
      msg.exc.code = stage.if2_misaligned ? e_instr_misaligned : e_instr_access_fault;
    else
      msg.instr = imem_data_i;
  end

  assign fe_queue_type_o    = exc_item ? e_fe_exception : e_fe_fetch;
  assign fe_queue_pc_o      = stage.if2_pc;
  assign fe_queue_payload_o = msg;

  a_valid_needs_ready: assert property (
    @(posedge stage.clk_i) disable iff (stage.reset_i)
    fe_queue_v_o |-> fe_queue_ready_i
  ) else $error("queue valid raised without ready");

  // IF1 must be poisoned once an exception goes out
  a_exc_drains_pipe: assert property (
    @(posedge stage.clk_i) disable iff (stage.reset_i)
    exc_v_o |=> !stage.if2_v
  ) else $error("item reached IF2 after an exception");

endmodule

//--- design/fe_top.sv
// Fetch front end top level joining decode, PC generation and both fetch stages
`timescale 1ns/1ps

module fe_top (
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  logic                           fe_cmd_v_i,
  input  fe_pkg::fe_opcode_e             fe_cmd_opcode_i,
  input  logic [fe_pkg::VADDR_WIDTH-1:0] fe_cmd_vaddr_i,
  output logic                           imem_v_o,
  output logic [fe_pkg::VADDR_WIDTH-1:0] imem_addr_o,
  input  logic [fe_pkg::INSTR_WIDTH-1:0] imem_data_i,
  output logic                           fe_queue_v_o,
  output fe_pkg::fe_msg_type_e           fe_queue_type_o,
  output logic [fe_pkg::VADDR_WIDTH-1:0] fe_queue_pc_o,
  output fe_pkg::fe_msg_u                fe_queue_payload_o,
  input  logic                           fe_queue_ready_i
);
  import fe_pkg::*;

  logic                   next_v;
  logic [VADDR_WIDTH-1:0] next_pc;
  logic                   fetch_fail;
  logic                   exc_v;

  fe_cmd_if cmd_if ();
  fe_stage_if stage_if (.clk_i(clk_i), .reset_i(reset_i));

  fe_cmd_decode u_cmd_decode (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .fe_cmd_v_i      (fe_cmd_v_i),
    .fe_cmd_opcode_i (fe_cmd_opcode_i),
    .fe_cmd_vaddr_i  (fe_cmd_vaddr_i),
    .cmd             (cmd_if.source)
  );

  // Memory has fixed latency, so queue ready is the only fetch gate
  fe_pc_gen u_pc_gen (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .cmd          (cmd_if.sink),
    .if2_pc_i     (stage_if.if2_pc),
    .fetch_fail_i (fetch_fail),
    .exc_v_i      (exc_v),
    .imem_ready_i (fe_queue_ready_i),
    .next_v_o     (next_v),
    .next_pc_o    (next_pc)
  );

  fe_fetch_stage u_fetch_stage (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .next_v_i     (next_v),
    .next_pc_i    (next_pc),
    .imem_v_o     (imem_v_o),
    .imem_addr_o  (imem_addr_o),
    .fetch_fail_i (fetch_fail),
    .exc_v_i      (exc_v),
    .cmd          (cmd_if.monitor),
    .stage        (stage_if.source)
  );

  fe_queue_stage u_queue_stage (
    .stage              (stage_if.sink),
    .cmd                (cmd_if.monitor),
    .imem_data_i        (imem_data_i),
    .fe_queue_ready_i   (fe_queue_ready_i),
    .fe_queue_v_o       (fe_queue_v_o),
    .fe_queue_type_o    (fe_queue_type_o),
    .fe_queue_pc_o      (fe_queue_pc_o),
    .fe_queue_payload_o (fe_queue_payload_o),
    .fetch_fail_o       (fetch_fail),
    .exc_v_o            (exc_v)
  );

endmodule

//--- project.f
+incdir+include
design/fe_pkg.sv
design/fe_if.sv
design/fe_cmd_decode.sv
design/fe_pc_gen.sv
design/fe_fetch_stage.sv
design/fe_queue_stage.sv
design/fe_top.sv
verification/fe_checker.sv
verification/fe_tb.sv

//--- include/fe_tb_mem.svh
// Instruction memory contents shared by the testbench memory model and the checker

function automatic logic [fe_pkg::INSTR_WIDTH-1:0] imem_word(
  input logic [fe_pkg::VADDR_WIDTH-1:0] addr
);
  logic [31:0] x;
  // Xorshift mix so every address bit reaches the word
  x = addr ^ 32'h9e37_79b9;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

//--- verification/fe_checker.sv
// Fetch queue checker that predicts every message from the command stream
`timescale 1ns/1ps

module fe_checker (
  input  logic                           clk_i,
  input  logic                           reset_i,
  input  logic                           fe_cmd_v_i,
  input  fe_pkg::fe_opcode_e             fe_cmd_opcode_i,
  input  logic [fe_pkg::VADDR_WIDTH-1:0] fe_cmd_vaddr_i,
  input  logic                           imem_v_i,
  input  logic [fe_pkg::VADDR_WIDTH-1:0] imem_addr_i,
  input  logic                           fe_queue_v_i,
  input  fe_pkg::fe_msg_type_e           fe_queue_type_i,
  input  logic [fe_pkg::VADDR_WIDTH-1:0] fe_queue_pc_i,
  input  fe_pkg::fe_msg_u                fe_queue_payload_i,
  input  logic                           fe_queue_ready_i,
  output int                             error_count_o,
  output int                             check_count_o,
  output int                             msg_count_o,
  output int                             exc_count_o
);
  import fe_pkg::*;

  `include "fe_tb_mem.svh"

  int                     error_count = 0;
  int                     check_count = 0;
  int                     msg_count = 0;
  int                     exc_count = 0;
  int                     lat_cnt = 0;
  logic                   active = 1'b0;
  logic                   seen_cmd = 1'b0;
  logic                   start_wait = 1'b0;
  logic [VADDR_WIDTH-1:0] exp_pc = '0;
  fe_msg_type_e           exp_type;
  logic [INSTR_WIDTH-1:0] exp_payload;

  // Expected message for a PC with misaligned ahead of access fault
  function automatic void expect_msg(
    input  logic [VADDR_WIDTH-1:0] pc,
    output fe_msg_type_e           msg_type,
    output logic [INSTR_WIDTH-1:0] payload
  );
    msg_type = e_fe_exception;
    if (pc[1:0] != 2'b00)
      payload = {{(INSTR_WIDTH-2){1'b0}}, e_instr_misaligned};
    else if (pc >= IMEM_LIMIT)
      payload = {{(INSTR_WIDTH-2){1'b0}}, e_instr_access_fault};
    else
    begin
      msg_type = e_fe_fetch;
      payload  = imem_word(pc);
    end
  endfunction

  task automatic report_error(input string what);
    $display("ERROR at %0t: %s", $time, what);
    error_count++;
  endtask

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    check_count++;
    if (exp !== act)
    begin
      $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, exp, act);
      error_count++;
    end
  endtask

  // Outputs are sampled mid cycle away from both clock edges
  always @(negedge clk_i)
  begin
    if (reset_i)
    begin
      active     = 1'b0;
      seen_cmd   = 1'b0;
      start_wait = 1'b0;
      lat_cnt    = 0;
    end
    else
    begin
      if (!seen_cmd && (imem_v_i || fe_queue_v_i))
        report_error("fetch activity before the first command");
      if (fe_queue_v_i && !fe_queue_ready_i)
        report_error("queue valid high while ready is low");
      if (fe_queue_v_i && fe_cmd_v_i)
        report_error("message delivered in a command cycle");

      // Faulting PCs never reach the memory
      if (imem_v_i && ((imem_addr_i[1:0] != 2'b00) || (imem_addr_i >= IMEM_LIMIT)))
        report_error("memory read issued for a faulting address");

      // First message is due two cycles after fetching starts
      if (lat_cnt > 0)
      begin
        lat_cnt = lat_cnt - 1;
        if (lat_cnt == 0 && fe_queue_ready_i && !fe_cmd_v_i && !fe_queue_v_i)
          report_error("no message two cycles after fetch start");
      end

      if (fe_queue_v_i)
      begin
        msg_count++;
        if (!active)
          report_error("message delivered with no fetch stream running");
        expect_msg(exp_pc, exp_type, exp_payload);
        check_word("fe_queue_pc_o", exp_pc, fe_queue_pc_i);
        check_word("fe_queue_type_o", {31'b0, exp_type}, {31'b0, fe_queue_type_i});
        check_word("fe_queue_payload_o", exp_payload, fe_queue_payload_i);
        if (fe_queue_type_i == e_fe_exception)
          exc_count++;
        if (exp_type == e_fe_exception)
          active = 1'b0;
        exp_pc = exp_pc + FETCH_STRIDE;
      end

      if (fe_cmd_v_i)
      begin
        seen_cmd   = 1'b1;
        exp_pc     = fe_cmd_vaddr_i;
        active     = (fe_cmd_opcode_i != e_op_wait);
        lat_cnt    = (fe_cmd_opcode_i == e_op_pc_redirect) ? 2 : 0;
        start_wait = (fe_cmd_opcode_i == e_op_state_reset);
      end
      else if (start_wait && fe_queue_ready_i)
      begin
        start_wait = 1'b0;
        lat_cnt    = 2;
      end
    end
  end

  assign error_count_o = error_count;
  assign check_count_o = check_count;
  assign msg_count_o   = msg_count;
  assign exc_count_o   = exc_count;

endmodule

//--- verification/fe_tb.sv
// Testbench for the fetch front end with memory model, queue back-pressure and test sequence
`timescale 1ns/1ps

module fe_tb;
  import fe_pkg::*;

  localparam int          RESET_CYCLES = 5;
  localparam int          IDLE_CYCLES  = 20;
  localparam int          STREAM_MSGS  = 16;
  localparam int          RANDOM_MSGS  = 48;
  localparam logic [31:0] LFSR_SEED    = 32'h5ff4;

  // Sum of test budgets with ten cycles per message under random ready
  localparam int CYCLE_LIMIT = RESET_CYCLES + IDLE_CYCLES + (STREAM_MSGS + 10)
                             + RANDOM_MSGS * 10 + 40 + (3 * IDLE_CYCLES + 150)
                             + (IDLE_CYCLES + 40) + 200;

  logic                   clk_i;
  logic                   reset_i;
  logic                   cmd_v;
  fe_opcode_e             cmd_opcode;
  logic [VADDR_WIDTH-1:0] cmd_vaddr;
  logic                   imem_v;
  logic [VADDR_WIDTH-1:0] imem_addr;
  logic [INSTR_WIDTH-1:0] imem_data;
  logic                   queue_v;
  fe_msg_type_e           queue_type;
  logic [VADDR_WIDTH-1:0] queue_pc;
  fe_msg_u                queue_payload;
  logic                   queue_ready;
  int                     error_count;
  int                     check_count;
  int                     msg_count;
  int                     exc_count;
  int                     cycle_count;
  int                     test_count;
  int                     errors_before;
  int                     stretch_left;
  logic [31:0]            lfsr_state;
  logic                   random_ready;
  logic                   ready_fixed;
  logic [7:0]             bits;
  logic                   rd_v;
  logic [VADDR_WIDTH-1:0] rd_addr;

  `include "fe_tb_mem.svh"

  fe_top UUT (
    .clk_i              (clk_i),
    .reset_i            (reset_i),
    .fe_cmd_v_i         (cmd_v),
    .fe_cmd_opcode_i    (cmd_opcode),
    .fe_cmd_vaddr_i     (cmd_vaddr),
    .imem_v_o           (imem_v),
    .imem_addr_o        (imem_addr),
    .imem_data_i        (imem_data),
    .fe_queue_v_o       (queue_v),
    .fe_queue_type_o    (queue_type),
    .fe_queue_pc_o      (queue_pc),
    .fe_queue_payload_o (queue_payload),
    .fe_queue_ready_i   (queue_ready)
  );

  fe_checker u_checker (
    .clk_i              (clk_i),
    .reset_i            (reset_i),
    .fe_cmd_v_i         (cmd_v),
    .fe_cmd_opcode_i    (cmd_opcode),
    .fe_cmd_vaddr_i     (cmd_vaddr),
    .imem_v_i           (imem_v),
    .imem_addr_i        (imem_addr),
    .fe_queue_v_i       (queue_v),
    .fe_queue_type_i    (queue_type),
    .fe_queue_pc_i      (queue_pc),
    .fe_queue_payload_i (queue_payload),
    .fe_queue_ready_i   (queue_ready),
    .error_count_o      (error_count),
    .check_count_o      (check_count),
    .msg_count_o        (msg_count),
    .exc_count_o        (exc_count)
  );

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0])
      return (s >> 1) ^ 32'h8020_0003;
    return s >> 1;
  endfunction

  task automatic draw_bits(input int n, output logic [7:0] v);
    int i;
    v = '0;
    for (i = 0; i < n; i++)
    begin
      v = {v[6:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  task automatic send_cmd(input fe_opcode_e op, input logic [VADDR_WIDTH-1:0] addr);
    @(posedge clk_i);
    #1;
    cmd_v      = 1'b1;
    cmd_opcode = op;
    cmd_vaddr  = addr;
    @(posedge clk_i);
    #1;
    cmd_v = 1'b0;
  endtask

  task automatic wait_msgs(input int n);
    int target;
    target = msg_count + n;
    while (msg_count < target)
      @(posedge clk_i);
  endtask

  task automatic wait_exception();
    int target;
    target = exc_count + 1;
    while (exc_count < target)
      @(posedge clk_i);
  endtask

  task automatic end_test(input string name);
    test_count++;
    if (error_count == errors_before)
      $display("test %0d %s: passed", test_count, name);
    else
      $display("test %0d %s: failed, %0d errors", test_count, name, error_count - errors_before);
    errors_before = error_count;
  endtask

  initial
  begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Memory answers one cycle after each read
  initial
  begin
    imem_data = '0;
    forever
    begin
      @(negedge clk_i);
      rd_v    = imem_v;
      rd_addr = imem_addr;
      @(posedge clk_i);
      #1;
      imem_data = rd_v ? imem_word(rd_addr) : '0;
    end
  end

  // Queue ready in random stretches of one to eight cycles and mostly high
  initial
  begin
    queue_ready  = 1'b1;
    stretch_left = 0;
    forever
    begin
      @(posedge clk_i);
      #1;
      if (random_ready)
      begin
        if (stretch_left == 0)
        begin
          draw_bits(2, bits);
          queue_ready = (bits[1:0] != 2'b00);
          draw_bits(3, bits);
          stretch_left = bits[2:0] + 1;
        end
        stretch_left = stretch_left - 1;
      end
      else
        queue_ready = ready_fixed;
    end
  end

  initial
  begin
    cycle_count = 0;
    while (cycle_count < CYCLE_LIMIT)
    begin
      @(posedge clk_i);
      cycle_count++;
    end
    $display("Timeout after %0d cycles, a test never finished", cycle_count);
    $display("** FAIL **");
    $finish;
  end

  initial
  begin
    reset_i       = 1'b1;
    cmd_v         = 1'b0;
    cmd_opcode    = e_op_wait;
    cmd_vaddr     = '0;
    random_ready  = 1'b0;
    ready_fixed   = 1'b1;
    lfsr_state    = LFSR_SEED;
    test_count    = 0;
    errors_before = 0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    #1;
    reset_i = 1'b0;

    repeat (IDLE_CYCLES) @(posedge clk_i);
    end_test("idle after reset");

    send_cmd(e_op_pc_redirect, 32'h0000_0100);
    wait_msgs(STREAM_MSGS);
    end_test("redirect stream");

    random_ready = 1'b1;
    send_cmd(e_op_pc_redirect, 32'h0000_0200);
    wait_msgs(RANDOM_MSGS);
    random_ready = 1'b0;
    end_test("random back-pressure");

    send_cmd(e_op_pc_redirect, 32'h0000_0300);
    wait_msgs(4);
    send_cmd(e_op_pc_redirect, 32'h0000_0800);
    wait_msgs(8);
    end_test("mid-stream redirect");

    send_cmd(e_op_pc_redirect, 32'h0000_0102);
    wait_exception();
    repeat (IDLE_CYCLES) @(posedge clk_i);
    // Misaligned and past the limit at once
    send_cmd(e_op_pc_redirect, 32'h0000_2006);
    wait_exception();
    repeat (IDLE_CYCLES) @(posedge clk_i);
    random_ready = 1'b1;
    send_cmd(e_op_pc_redirect, IMEM_LIMIT - 32'h20);
    wait_exception();
    random_ready = 1'b0;
    repeat (IDLE_CYCLES) @(posedge clk_i);
    end_test("fetch exceptions");

    send_cmd(e_op_pc_redirect, 32'h0000_0400);
    wait_msgs(4);
    send_cmd(e_op_wait, '0);
    repeat (IDLE_CYCLES) @(posedge clk_i);
    ready_fixed = 1'b0;
    send_cmd(e_op_state_reset, 32'h0000_0600);
    repeat (4) @(posedge clk_i);
    ready_fixed = 1'b1;
    wait_msgs(8);
    end_test("wait then state reset");

    $display("%0d tests, %0d checks, %0d messages, %0d errors",
             test_count, check_count, msg_count, error_count);
    if (error_count == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule
